// File: list.f
+incdir+common
+incdir+sim
common/minimig_pkg.sv
common/chip_bus_if.sv
common/reg_bus_if.sv
chip/chip_arbiter.sv
chip/chip_ram.sv
paula/disk_dma.sv
paula/int_ctrl.sv
src/cpu_bridge.sv
src/minimig_core.sv
sim/tb_minimig.sv

// File: Bender.yml
package:
  name: minimig_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/minimig_pkg.sv
      - common/chip_bus_if.sv
      - common/reg_bus_if.sv
      - chip/chip_arbiter.sv
      - chip/chip_ram.sv
      - paula/disk_dma.sv
      - paula/int_ctrl.sv
      - src/cpu_bridge.sv
      - src/minimig_core.sv
  - target: simulation
    include_dirs:
      - common
      - sim
    files:
      - sim/tb_minimig.sv

// File: sim/tb_minimig_model.svh
// minimig testbench model: chip RAM image, interrupt registers and 68000 bus cycle tasks
`ifndef TB_MINIMIG_MODEL_SVH
`define TB_MINIMIG_MODEL_SVH

word_t       ram_model [0:`MM_CHIP_WORDS-1];   // expected chip RAM contents
logic [14:0] ena_model;                        // INTENA
logic [14:0] req_model;                        // INTREQ

// drive point is 5 units after the rising edge
task automatic next_cycles(input int n);
  repeat (n) begin
    @(posedge clk);
    #5;
  end
endtask

// only the lanes that UDS/LDS enable
task automatic apply_ram_write(input chip_addr_t a, input word_t d, input byte_en_t be);
  if (be[1]) ram_model[a][15:8] = d[15:8];
  if (be[0]) ram_model[a][7:0]  = d[7:0];
endtask

// bit 15 picks set or clear, bits 14:0 are the mask
function automatic logic [14:0] set_clear(input logic [14:0] cur, input word_t w);
  if (w[15]) return cur | w[14:0];
  return cur & ~w[14:0];
endfunction

// PORTS is level 2, DSKBLK level 1, nothing pending gives all ones
function automatic logic [2:0] expected_ipl();
  logic [14:0] act;
  act = ena_model[`MM_INT_MASTER] ? (req_model & ena_model) : 15'h0000;
  if (act[`MM_INT_PORTS])  return ~3'd2;
  if (act[`MM_INT_DSKBLK]) return ~3'd1;
  return 3'b111;
endfunction

// byte offset in the custom block -> CPU word address
function automatic logic [`MM_ADDR_W-1:0] reg_loc(input logic [8:0] off);
  logic [23:0] byte_addr;
  byte_addr = {`MM_CUSTOM_BASE, 12'h000} | 24'(off);
  return byte_addr[23:1];
endfunction

function automatic logic [`MM_ADDR_W-1:0] chip_loc(input chip_addr_t a);
  return {{(`MM_ADDR_W-`MM_CHIP_AW){1'b0}}, a};
endfunction

// --------------------
// one 68000 cycle: AS low, wait DTACK, release, wait DTACK high
task automatic bus_cycle(input logic [`MM_ADDR_W-1:0] addr, input logic rd_cycle,
                         input word_t wdata, input byte_en_t be, output word_t rdata);
  int n;
  cpu_addr  = addr;
  cpu_wdata = wdata;
  cpu_r_w   = rd_cycle;
  cpu_uds_n = ~be[1];
  cpu_lds_n = ~be[0];
  cpu_as_n  = 1'b0;
  n = 0;
  while (cpu_dtack_n && n < 50) begin
    next_cycles(1);
    n++;
  end
  if (cpu_dtack_n) begin
    $display("bus cycle to %h hung, no DTACK within 50 cycles", addr);
    errors++;
  end
  rdata     = cpu_rdata;           // valid while DTACK is low
  cpu_as_n  = 1'b1;
  cpu_uds_n = 1'b1;
  cpu_lds_n = 1'b1;
  n = 0;
  while (!cpu_dtack_n && n < 50) begin
    next_cycles(1);
    n++;
  end
  if (!cpu_dtack_n) begin
    $display("DTACK stayed low after AS was released, address %h", addr);
    errors++;
  end
endtask

task automatic bus_write(input logic [`MM_ADDR_W-1:0] addr, input word_t d, input byte_en_t be);
  word_t unused;
  bus_cycle(addr, 1'b0, d, be, unused);
endtask

task automatic bus_read(input logic [`MM_ADDR_W-1:0] addr, output word_t d);
  bus_cycle(addr, 1'b1, 16'h0000, 2'b11, d);
endtask

`endif

// File: sim/tb_minimig.sv
// minimig core testbench: random CPU, disk DMA and interrupt traffic against a model
`default_nettype none

`include "minimig_macros.svh"

module tb_minimig;
  import minimig_pkg::*;

  localparam int T_CLK     = 40;
  localparam int OPS_TOTAL = 800;   // bus cycles and disk words over all tests, rounded up

  logic                  clk = 1'b0;
  logic                  reset;
  logic [`MM_ADDR_W-1:0] cpu_addr;
  word_t                 cpu_wdata, cpu_rdata;
  logic                  cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_r_w;
  logic                  cpu_dtack_n;
  logic [2:0]            cpu_ipl_n;
  logic                  disk_strobe, ext_int2;
  word_t                 disk_data;

  int         errors, tests_passed, tests_failed, seed_val, n, e0;
  word_t      rd, d;
  chip_addr_t a, wptr;
  byte_en_t   be;
  chip_addr_t written [$];          // addresses with a known word

  `include "tb_minimig_model.svh"

  minimig_core u_minimig_core (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr_i   (cpu_addr),
    .cpu_data_i   (cpu_wdata),
    .cpu_data_o   (cpu_rdata),
    .cpu_as_n_i   (cpu_as_n),
    .cpu_uds_n_i  (cpu_uds_n),
    .cpu_lds_n_i  (cpu_lds_n),
    .cpu_r_w_i    (cpu_r_w),
    .cpu_dtack_n_o(cpu_dtack_n),
    .cpu_ipl_n_o  (cpu_ipl_n),
    .disk_strobe_i(disk_strobe),
    .disk_data_i  (disk_data),
    .ext_int2_i   (ext_int2)
  );

  always #(T_CLK / 2) clk = ~clk;

  // about 20 cycles per operation
  initial begin
    #(OPS_TOTAL * 20 * T_CLK);
    $display("timeout: run still busy after %0d time units", OPS_TOTAL * 20 * T_CLK);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check_value(input string what, input word_t got, input word_t exp);
    assert (got === exp)
      else begin
        $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  // --------------------
  // disk side
  task automatic arm_disk(input chip_addr_t ptr, input int len);
    bus_write(reg_loc(`MM_REG_DSKPTH), 16'h0000, 2'b11);
    bus_write(reg_loc(`MM_REG_DSKPTL), {3'b000, ptr, 1'b0}, 2'b11);   // byte pointer
    bus_write(reg_loc(`MM_REG_DSKLEN), {1'b1, 1'b0, 14'(len)}, 2'b11);
  endtask

  task automatic send_disk_word(input word_t w);
    disk_strobe = 1'b1;
    disk_data   = w;
    next_cycles(1);
    disk_strobe = 1'b0;
    next_cycles(3 + $urandom % 5);  // strobes 4 to 8 cycles apart
  endtask

  task automatic run_disk_block(input chip_addr_t ptr, input int len);
    word_t w;
    for (int i = 0; i < len; i++) begin
      w = word_t'($urandom);
      apply_ram_write(chip_addr_t'(ptr + i), w, 2'b11);
      send_disk_word(w);
    end
    req_model[`MM_INT_DSKBLK] = 1'b1;   // block done
  endtask

  initial begin
    seed_val    = $urandom(9);
    reset       = 1'b1;
    cpu_addr    = '0;
    cpu_wdata   = '0;
    cpu_as_n    = 1'b1;
    cpu_uds_n   = 1'b1;
    cpu_lds_n   = 1'b1;
    cpu_r_w     = 1'b1;
    disk_strobe = 1'b0;
    disk_data   = '0;
    ext_int2    = 1'b0;
    ena_model   = '0;
    req_model   = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    next_cycles(2);

    e0 = errors;
    check_value("DTACK after reset", word_t'(cpu_dtack_n), 16'h0001);
    check_value("IPL after reset", word_t'(cpu_ipl_n), 16'h0007);
    bus_read(reg_loc(`MM_REG_INTENAR), rd);
    check_value("INTENAR after reset", rd, 16'h0000);
    bus_read(reg_loc(`MM_REG_INTREQR), rd);
    check_value("INTREQR after reset", rd, 16'h0000);
    report_test("reset state", e0);

    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      a  = chip_addr_t'($urandom);
      d  = word_t'($urandom);
      be = byte_en_t'(1 + $urandom % 3);   // at least one lane
      bus_write(chip_loc(a), d, be);
      apply_ram_write(a, d, be);
      written.push_back(a);
    end
    for (int i = 0; i < 200; i++) begin
      a = written[$urandom % written.size()];
      bus_read(chip_loc(a), rd);
      check_value("chip RAM word", rd, ram_model[a]);
    end
    report_test("chip RAM access", e0);

    e0 = errors;
    for (int i = 0; i < 30; i++) begin
      d = word_t'($urandom);
      bus_write(reg_loc(`MM_REG_INTENA), d, 2'b11);
      ena_model = set_clear(ena_model, d);
      bus_read(reg_loc(`MM_REG_INTENAR), rd);
      check_value("INTENAR", rd, {1'b0, ena_model});
    end
    report_test("INTENA set/clear", e0);

    // --------------------
    e0   = errors;
    n    = 1 + $urandom % 32;
    wptr = chip_addr_t'($urandom % (`MM_CHIP_WORDS - 33));
    arm_disk(wptr, n);
    run_disk_block(wptr, n);
    for (int i = 0; i < n; i++) begin
      bus_read(chip_loc(chip_addr_t'(wptr + i)), rd);
      check_value("disk word in chip RAM", rd, ram_model[wptr + i]);
    end
    bus_read(reg_loc(`MM_REG_DSKPTH), rd);
    check_value("DSKPTH after block", rd, 16'h0000);
    bus_read(reg_loc(`MM_REG_DSKPTL), rd);
    check_value("DSKPTL after block", rd, word_t'((wptr + n) * 2));
    bus_read(reg_loc(`MM_REG_INTREQR), rd);
    check_value("INTREQR DSKBLK", word_t'(rd[`MM_INT_DSKBLK]), 16'h0001);
    send_disk_word(word_t'($urandom));   // disarmed now, dropped
    bus_read(chip_loc(chip_addr_t'(wptr + n)), rd);
    check_value("word past the block", rd, ram_model[wptr + n]);
    report_test("disk DMA", e0);

    e0   = errors;
    n    = 16 + $urandom % 17;
    wptr = chip_addr_t'(2048 + $urandom % 1024);   // DMA upper half, CPU lower half
    arm_disk(wptr, n);
    fork
      run_disk_block(wptr, n);
      for (int i = 0; i < 30; i++) begin
        a  = chip_addr_t'($urandom % 2048);
        d  = word_t'($urandom);
        be = byte_en_t'(1 + $urandom % 3);
        bus_write(chip_loc(a), d, be);
        apply_ram_write(a, d, be);
        bus_read(chip_loc(a), rd);
        check_value("CPU word under DMA", rd, ram_model[a]);
      end
    join
    for (int i = 0; i < n; i++) begin
      bus_read(chip_loc(chip_addr_t'(wptr + i)), rd);
      check_value("DMA word under CPU load", rd, ram_model[wptr + i]);
    end
    report_test("contention", e0);

    // --------------------
    e0 = errors;
    for (int c = 0; c < 8; c++) begin
      bus_write(reg_loc(`MM_REG_INTENA), 16'h7FFF, 2'b11);   // clear all
      bus_write(reg_loc(`MM_REG_INTREQ), 16'h7FFF, 2'b11);
      ena_model = '0;
      req_model = '0;
      d = 16'h8000;
      d[`MM_INT_DSKBLK] = c[0];
      d[`MM_INT_PORTS]  = c[1];
      d[`MM_INT_MASTER] = c[2];
      bus_write(reg_loc(`MM_REG_INTENA), d, 2'b11);
      ena_model = set_clear(ena_model, d);
      ext_int2 = 1'b1;
      next_cycles(1);
      ext_int2 = 1'b0;
      req_model[`MM_INT_PORTS] = 1'b1;
      next_cycles(3);
      check_value("IPL after PORTS", word_t'(cpu_ipl_n), word_t'(expected_ipl()));
      arm_disk(chip_addr_t'(3000 + c), 1);
      run_disk_block(chip_addr_t'(3000 + c), 1);
      next_cycles(3);
      check_value("IPL after DSKBLK", word_t'(cpu_ipl_n), word_t'(expected_ipl()));
      d = 16'h0000;
      d[`MM_INT_PORTS] = 1'b1;
      bus_write(reg_loc(`MM_REG_INTREQ), d, 2'b11);   // drop PORTS only
      req_model = set_clear(req_model, d);
      next_cycles(3);
      check_value("IPL after PORTS clear", word_t'(cpu_ipl_n), word_t'(expected_ipl()));
      bus_write(reg_loc(`MM_REG_INTREQ), 16'h7FFF, 2'b11);
      req_model = '0;
      next_cycles(3);
      check_value("IPL after INTREQ clear", word_t'(cpu_ipl_n), 16'h0007);
    end
    report_test("interrupt levels", e0);

    $display("tests: %0d ok, %0d with errors, %0d errors in all",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/minimig_core.sv
// minimig core: CPU bridge and disk DMA sharing chip RAM, plus the interrupt controller
`default_nettype none

`include "minimig_macros.svh"

module minimig_core (
  input  logic                  clk,
  input  logic                  reset,
  // 68000 side
  input  logic [`MM_ADDR_W-1:0] cpu_addr_i,     // A23:A1
  input  minimig_pkg::word_t    cpu_data_i,
  output minimig_pkg::word_t    cpu_data_o,
  input  logic                  cpu_as_n_i,
  input  logic                  cpu_uds_n_i,
  input  logic                  cpu_lds_n_i,
  input  logic                  cpu_r_w_i,
  output logic                  cpu_dtack_n_o,
  output logic [2:0]            cpu_ipl_n_o,
  // disk data stream
  input  logic                  disk_strobe_i,
  input  minimig_pkg::word_t    disk_data_i,
  input  logic                  ext_int2_i       // PORTS interrupt source
);
  import minimig_pkg::*;

  chip_bus_if cpu_chip ();   // bridge -> arbiter
  chip_bus_if dma_chip ();   // disk dma -> arbiter
  chip_bus_if ram_port ();   // arbiter -> RAM
  reg_bus_if  reg_bus  ();

  word_t dma_rdata;          // custom read words, ORed in the bridge
  word_t int_rdata;
  logic  dskblk;

  cpu_bridge u_cpu_bridge (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_data_i   (cpu_data_i),
    .cpu_as_n_i   (cpu_as_n_i),
    .cpu_uds_n_i  (cpu_uds_n_i),
    .cpu_lds_n_i  (cpu_lds_n_i),
    .cpu_r_w_i    (cpu_r_w_i),
    .cpu_data_o   (cpu_data_o),
    .cpu_dtack_n_o(cpu_dtack_n_o),
    .chip         (cpu_chip),
    .regs         (reg_bus),
    .dma_rdata_i  (dma_rdata),
    .int_rdata_i  (int_rdata)
  );

  chip_arbiter u_chip_arbiter (
    .clk  (clk),
    .reset(reset),
    .cpu  (cpu_chip),
    .dma  (dma_chip),
    .ram  (ram_port)
  );

  chip_ram u_chip_ram (
    .clk(clk),
    .bus(ram_port)
  );

  disk_dma u_disk_dma (
    .clk          (clk),
    .reset        (reset),
    .regs         (reg_bus),
    .rdata_o      (dma_rdata),
    .chip         (dma_chip),
    .disk_strobe_i(disk_strobe_i),
    .disk_data_i  (disk_data_i),
    .dskblk_o     (dskblk)
  );

  int_ctrl u_int_ctrl (
    .clk       (clk),
    .reset     (reset),
    .regs      (reg_bus),
    .rdata_o   (int_rdata),
    .dskblk_i  (dskblk),
    .ext_int2_i(ext_int2_i),
    .ipl_n_o   (cpu_ipl_n_o)
  );

endmodule

`default_nettype wire

// File: src/cpu_bridge.sv
// 68000 bus bridge: cycle detection, address decode, DTACK timing and read data capture
`default_nettype none

`include "minimig_macros.svh"

module cpu_bridge (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`MM_ADDR_W-1:0] cpu_addr_i,     // index 0 is A1
  input  minimig_pkg::word_t    cpu_data_i,
  input  logic                  cpu_as_n_i,
  input  logic                  cpu_uds_n_i,
  input  logic                  cpu_lds_n_i,
  input  logic                  cpu_r_w_i,
  output minimig_pkg::word_t    cpu_data_o,
  output logic                  cpu_dtack_n_o,
  chip_bus_if.master            chip,
  reg_bus_if.master             regs,
  input  minimig_pkg::word_t    dma_rdata_i,
  input  minimig_pkg::word_t    int_rdata_i
);
  import minimig_pkg::*;

  localparam int CUST_LSB = `MM_ADDR_W - 12;   // A12, custom block is 4K bytes

  typedef enum logic [2:0] {S_IDLE, S_REG, S_CHIP, S_RDWAIT, S_ACK} state_e;

  state_e     state_q;
  logic       as_q, as_qq;            // AS synchronizer
  logic       as_fall;
  logic       sel_chip, sel_reg;
  logic       dtack_n_q;
  logic       req_q, we_q;
  logic       wr_q, rd_q;
  chip_addr_t addr_q;
  reg_addr_t  raddr_q;
  byte_en_t   be_q;
  word_t      wdata_q;                // shared by chip and register writes
  word_t      data_q;                 // read data held for the CPU

  assign as_fall  = as_qq & ~as_q;
  assign sel_chip = (cpu_addr_i[`MM_ADDR_W-1:`MM_CHIP_AW] == '0);   // below chip RAM top
  assign sel_reg  = (cpu_addr_i[`MM_ADDR_W-1:CUST_LSB] == `MM_CUSTOM_BASE);

  // --------------------
  // cycle FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= S_IDLE;
      as_q      <= 1'b1;
      as_qq     <= 1'b1;
      dtack_n_q <= 1'b1;
      req_q     <= 1'b0;
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
    end else begin
      as_q  <= cpu_as_n_i;
      as_qq <= as_q;
      wr_q  <= 1'b0;                  // strobes last a single cycle
      rd_q  <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (as_fall && sel_chip) begin
            req_q   <= 1'b1;
            state_q <= S_CHIP;
          end else if (as_fall) begin
            wr_q    <= sel_reg & ~cpu_r_w_i;   // unmapped: no strobe, reads zero
            rd_q    <= sel_reg & cpu_r_w_i;
            state_q <= S_REG;
          end
        end
        S_REG: begin                  // fixed latency, data captured below
          dtack_n_q <= 1'b0;
          state_q   <= S_ACK;
        end
        S_CHIP: begin
          if (chip.gnt) begin
            req_q     <= 1'b0;
            dtack_n_q <= ~we_q;       // writes end one cycle after gnt
            state_q   <= we_q ? S_ACK : S_RDWAIT;
          end
        end
        S_RDWAIT: begin
          if (chip.rvalid) begin
            dtack_n_q <= 1'b0;
            state_q   <= S_ACK;
          end
        end
        S_ACK: begin
          if (as_q) begin             // hold DTACK until AS rises
            dtack_n_q <= 1'b1;
            state_q   <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // address, strobes and data latched at cycle start
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && as_fall) begin
      we_q    <= ~cpu_r_w_i;
      addr_q  <= cpu_addr_i[`MM_CHIP_AW-1:0];
      raddr_q <= cpu_addr_i[`MM_REG_AW-1:0];
      be_q    <= {~cpu_uds_n_i, ~cpu_lds_n_i};
      wdata_q <= cpu_data_i;
    end
    if (state_q == S_REG)
      data_q <= rd_q ? (dma_rdata_i | int_rdata_i) : '0;   // custom words ORed
    else if (state_q == S_RDWAIT && chip.rvalid)
      data_q <= chip.rdata;
  end

  assign chip.req      = req_q;
  assign chip.we       = we_q;
  assign chip.addr     = addr_q;
  assign chip.be       = be_q;
  assign chip.wdata    = wdata_q;
  assign regs.wr       = wr_q;
  assign regs.rd       = rd_q;
  assign regs.addr     = raddr_q;
  assign regs.wdata    = wdata_q;
  assign cpu_data_o    = data_q;
  assign cpu_dtack_n_o = dtack_n_q;

  a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(regs.wr && regs.rd));

endmodule

`default_nettype wire

// File: paula/int_ctrl.sv
// interrupt controller: INTENA/INTREQ set/clear registers and CPU interrupt level
`default_nettype none

`include "minimig_macros.svh"

module int_ctrl (
  input  logic               clk,
  input  logic               reset,
  reg_bus_if.slave           regs,
  output minimig_pkg::word_t rdata_o,
  input  logic               dskblk_i,     // pulse from disk DMA
  input  logic               ext_int2_i,
  output logic [2:0]         ipl_n_o
);
  import minimig_pkg::*;

  localparam reg_addr_t A_INTENAR = reg_addr_t'(`MM_REG_INTENAR >> 1);
  localparam reg_addr_t A_INTREQR = reg_addr_t'(`MM_REG_INTREQR >> 1);
  localparam reg_addr_t A_INTENA  = reg_addr_t'(`MM_REG_INTENA >> 1);
  localparam reg_addr_t A_INTREQ  = reg_addr_t'(`MM_REG_INTREQ >> 1);
  localparam int        BITS      = `MM_WORD_W - 1;

  custom_word_u    wr_word;
  logic [BITS-1:0] intena_q, intreq_q;
  logic [BITS-1:0] intena_d, intreq_d;
  logic [BITS-1:0] pending;
  logic [2:0]      level;
  logic [2:0]      ipl_n_q;

  function automatic logic [BITS-1:0] set_clr(input logic [BITS-1:0] cur,
                                               input custom_word_u w);
    return w.sc.set_clr ? (cur | w.sc.mask) : (cur & ~w.sc.mask);
  endfunction

  assign wr_word.raw = regs.wdata;

  always_comb begin
    intena_d = intena_q;
    intreq_d = intreq_q;
    if (regs.wr && regs.addr == A_INTENA) intena_d = set_clr(intena_q, wr_word);
    if (regs.wr && regs.addr == A_INTREQ) intreq_d = set_clr(intreq_q, wr_word);
    if (dskblk_i)   intreq_d[`MM_INT_DSKBLK] = 1'b1;   // hardware set beats a clear
    if (ext_int2_i) intreq_d[`MM_INT_PORTS]  = 1'b1;
  end

  // --------------------
  // priority, PORTS over DSKBLK
  assign pending = intreq_q & intena_q & {BITS{intena_q[`MM_INT_MASTER]}};

  always_comb begin
    if (pending[`MM_INT_PORTS])       level = 3'd2;
    else if (pending[`MM_INT_DSKBLK]) level = 3'd1;
    else                              level = 3'd0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      intena_q <= '0;
      intreq_q <= '0;
      ipl_n_q  <= 3'b111;
    end else begin
      intena_q <= intena_d;
      intreq_q <= intreq_d;
      ipl_n_q  <= ~level;           // active low to the CPU
    end
  end

  always_comb begin
    case (regs.addr)
      A_INTENAR: rdata_o = {1'b0, intena_q};
      A_INTREQR: rdata_o = {1'b0, intreq_q};
      default:   rdata_o = '0;
    endcase
  end

  assign ipl_n_o = ipl_n_q;

endmodule

`default_nettype wire

// File: paula/disk_dma.sv
// disk DMA: DSKPT/DSKLEN registers, one-word buffer and chip RAM write requests
`default_nettype none

`include "minimig_macros.svh"

module disk_dma (
  input  logic               clk,
  input  logic               reset,
  reg_bus_if.slave           regs,
  output minimig_pkg::word_t rdata_o,
  chip_bus_if.master         chip,
  input  logic               disk_strobe_i,
  input  minimig_pkg::word_t disk_data_i,
  output logic               dskblk_o
);
  import minimig_pkg::*;

  localparam reg_addr_t A_DSKPTH = reg_addr_t'(`MM_REG_DSKPTH >> 1);
  localparam reg_addr_t A_DSKPTL = reg_addr_t'(`MM_REG_DSKPTL >> 1);
  localparam reg_addr_t A_DSKLEN = reg_addr_t'(`MM_REG_DSKLEN >> 1);
  localparam int        PTR_W    = 2 * `MM_WORD_W - 1;   // byte address bits 31:1

  custom_word_u     wr_word;
  logic [PTR_W-1:0] ptr_q;
  logic [13:0]      len_q;      // words left in the block
  logic             armed_q;
  logic             req_q;      // buffer full, write pending
  logic             dskblk_q;
  logic             take;       // strobe accepted
  word_t            buf_q;

  assign wr_word.raw = regs.wdata;
  assign take        = armed_q & disk_strobe_i;   // strobes ignored while disarmed

  // --------------------
  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      armed_q  <= 1'b0;
      req_q    <= 1'b0;
      dskblk_q <= 1'b0;
    end else begin
      dskblk_q <= 1'b0;
      if (take)
        req_q <= 1'b1;
      if (chip.gnt) begin
        req_q <= 1'b0;
        if (len_q == 14'd1) begin   // last word out
          armed_q  <= 1'b0;
          dskblk_q <= 1'b1;
        end
      end
      if (regs.wr && regs.addr == A_DSKLEN)   // single write arms
        armed_q <= wr_word.dsklen.dma_en && (wr_word.dsklen.len != '0);
    end
  end

  // pointer, length and word buffer, register writes win
  always_ff @(posedge clk) begin
    if (take)
      buf_q <= disk_data_i;
    if (chip.gnt) begin
      ptr_q <= ptr_q + 1'b1;
      len_q <= len_q - 1'b1;
    end
    if (regs.wr) begin
      case (regs.addr)
        A_DSKPTH: ptr_q[PTR_W-1:`MM_WORD_W-1] <= regs.wdata;
        A_DSKPTL: ptr_q[`MM_WORD_W-2:0]       <= regs.wdata[`MM_WORD_W-1:1];
        A_DSKLEN: len_q                       <= wr_word.dsklen.len;
        default: ;
      endcase
    end
  end

  // pointer readback, zero for other offsets
  always_comb begin
    case (regs.addr)
      A_DSKPTH: rdata_o = ptr_q[PTR_W-1:`MM_WORD_W-1];
      A_DSKPTL: rdata_o = {ptr_q[`MM_WORD_W-2:0], 1'b0};
      default:  rdata_o = '0;
    endcase
  end

  assign chip.req   = req_q;
  assign chip.we    = 1'b1;               // disk to RAM only
  assign chip.addr  = ptr_q[`MM_CHIP_AW-1:0];
  assign chip.be    = 2'b11;
  assign chip.wdata = buf_q;
  assign dskblk_o   = dskblk_q;

  // strobe spacing vs arbiter latency
  a_no_overrun: assert property (@(posedge clk) disable iff (reset) disk_strobe_i |-> !req_q);

endmodule

`default_nettype wire

// File: chip/chip_ram.sv
// chip RAM: 4K x 16 array, byte-enabled writes, registered read one cycle after grant
`default_nettype none

`include "minimig_macros.svh"

module chip_ram (
  input  logic    clk,
  chip_bus_if.ram bus
);
  import minimig_pkg::*;

  localparam int HI = `MM_WORD_W / 2;   // first bit of the upper byte

  word_t mem [0:`MM_CHIP_WORDS-1];
  word_t rdata_q;
  logic  rvalid_q;

  always_ff @(posedge clk) begin
    if (bus.req && bus.we) begin
      if (bus.be[1]) mem[bus.addr][`MM_WORD_W-1:HI] <= bus.wdata[`MM_WORD_W-1:HI];
      if (bus.be[0]) mem[bus.addr][HI-1:0]          <= bus.wdata[HI-1:0];
    end
    if (bus.req && !bus.we)
      rdata_q <= mem[bus.addr];
    rvalid_q <= bus.req & ~bus.we;
  end

  assign bus.gnt    = bus.req;         // always ready
  assign bus.rdata  = rdata_q;
  assign bus.rvalid = rvalid_q;

  // UDS/LDS from the CPU or a DMA word, one lane at least
  a_write_lanes: assert property (@(posedge clk) (bus.req && bus.we) |-> (bus.be != 2'b00));

endmodule

`default_nettype wire

// File: chip/chip_arbiter.sv
// chip bus arbiter: one RAM access per cycle, disk DMA ahead of the CPU
`default_nettype none

module chip_arbiter (
  input  logic         clk,
  input  logic         reset,
  chip_bus_if.arbiter  cpu,
  chip_bus_if.arbiter  dma,
  chip_bus_if.master   ram
);
  import minimig_pkg::*;

  logic       dma_ok, cpu_ok;   // requests not already granted
  logic       req_q, we_q;
  logic       sel_dma_q;        // owner of the access now at the RAM
  logic       ret_dma_q;        // owner of the read data now returning
  chip_addr_t addr_q;
  byte_en_t   be_q;
  word_t      wdata_q;

  // a master still holds req in its gnt cycle, so mask it there
  assign dma_ok = dma.req & ~dma.gnt;
  assign cpu_ok = cpu.req & ~cpu.gnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q     <= 1'b0;
      sel_dma_q <= 1'b0;
      ret_dma_q <= 1'b0;
    end else begin
      req_q     <= dma_ok | cpu_ok;
      sel_dma_q <= dma_ok;          // DMA always wins
      ret_dma_q <= sel_dma_q;
    end
  end

  always_ff @(posedge clk) begin
    we_q    <= dma_ok ? dma.we    : cpu.we;
    addr_q  <= dma_ok ? dma.addr  : cpu.addr;
    be_q    <= dma_ok ? dma.be    : cpu.be;
    wdata_q <= dma_ok ? dma.wdata : cpu.wdata;
  end

  assign ram.req    = req_q;
  assign ram.we     = we_q;
  assign ram.addr   = addr_q;
  assign ram.be     = be_q;
  assign ram.wdata  = wdata_q;

  assign dma.gnt    = ram.gnt & sel_dma_q;
  assign cpu.gnt    = ram.gnt & ~sel_dma_q;
  assign dma.rvalid = ram.rvalid & ret_dma_q;
  assign cpu.rvalid = ram.rvalid & ~ret_dma_q;
  assign dma.rdata  = ram.rdata;
  assign cpu.rdata  = ram.rdata;

  a_one_grant: assert property (@(posedge clk) disable iff (reset) !(cpu.gnt && dma.gnt));

endmodule

`default_nettype wire

// File: common/reg_bus_if.sv
// custom register bus: single-cycle write and read strobes from the CPU bridge
`default_nettype none

interface reg_bus_if;
  import minimig_pkg::*;

  logic      wr;      // one-cycle write strobe
  logic      rd;      // one-cycle read strobe
  reg_addr_t addr;    // A8:A1
  word_t     wdata;

  modport master (
    output wr, rd, addr, wdata
  );

  // every slave listens, read data goes back on its own port
  modport slave (
    input  wr, rd, addr, wdata
  );

endinterface

`default_nettype wire

// File: common/chip_bus_if.sv
// chip RAM bus: request/grant from a master, read data returned one cycle after grant
`default_nettype none

interface chip_bus_if;
  import minimig_pkg::*;

  logic       req;      // held until gnt
  logic       we;
  chip_addr_t addr;
  byte_en_t   be;
  word_t      wdata;
  logic       gnt;      // one-cycle pulse, access issued to RAM
  word_t      rdata;
  logic       rvalid;   // one cycle after a read gnt

  modport master (
    output req, we, addr, be, wdata,
    input  gnt, rdata, rvalid
  );

  modport arbiter (
    input  req, we, addr, be, wdata,
    output gnt, rdata, rvalid
  );

  modport ram (
    input  req, we, addr, be, wdata,
    output gnt, rdata, rvalid
  );

endinterface

`default_nettype wire

// File: common/minimig_pkg.sv
// minimig shared types: data words, bus addresses and the custom register word views
`default_nettype none

`include "minimig_macros.svh"

package minimig_pkg;

  typedef logic [`MM_WORD_W-1:0]  word_t;
  typedef logic [`MM_CHIP_AW-1:0] chip_addr_t;   // chip RAM word address
  typedef logic [`MM_REG_AW-1:0]  reg_addr_t;    // register offset, A8:A1
  typedef logic [1:0]             byte_en_t;     // [1] upper byte, [0] lower byte

  // set/clear format of INTENA and INTREQ writes
  typedef struct packed {
    logic                  set_clr;   // 1 sets masked bits, 0 clears them
    logic [`MM_WORD_W-2:0] mask;
  } setclr_t;

  // DSKLEN write format
  typedef struct packed {
    logic        dma_en;
    logic        dir;                 // write direction, only disk-to-RAM is built
    logic [13:0] len;                 // words in the block
  } dsklen_t;

  // one register-bus word, seen raw or through a register's own layout
  typedef union packed {
    word_t   raw;
    setclr_t sc;
    dsklen_t dsklen;
  } custom_word_u;

endpackage

`default_nettype wire

// File: common/minimig_macros.svh
// minimig core macros: bus widths, chip RAM size, custom register map and interrupt bits
`ifndef MINIMIG_MACROS_SVH
`define MINIMIG_MACROS_SVH

// --------------------
// widths and sizes
`define MM_WORD_W        16
`define MM_ADDR_W        23          // A23:A1
`define MM_CHIP_AW       12          // 4K words of chip RAM
`define MM_CHIP_WORDS    (1 << `MM_CHIP_AW)
`define MM_CUSTOM_BASE   12'hDFF     // A23:A12 of the custom block
`define MM_REG_AW        8           // A8:A1 register offset

// --------------------
// custom register byte offsets
`define MM_REG_INTENAR   9'h01C      // read only
`define MM_REG_INTREQR   9'h01E      // read only
`define MM_REG_DSKPTH    9'h020
`define MM_REG_DSKPTL    9'h022
`define MM_REG_DSKLEN    9'h024      // write only
`define MM_REG_INTENA    9'h09A      // set/clear write
`define MM_REG_INTREQ    9'h09C      // set/clear write

// --------------------
// INTENA / INTREQ bit positions
`define MM_INT_DSKBLK    1           // disk block done, level 1
`define MM_INT_PORTS     3           // external int2, level 2
`define MM_INT_MASTER    14          // master enable, INTENA only

`endif
